//--- content_scan.f
+incdir+common
common/scan_pkg.sv
design/stream_dispatch.sv
stream_ctx/stream_ctx_unit.sv
matchers/finger_matcher.sv
matchers/root_matcher.sv
design/content_scan_top.sv
verif/content_scan_sva.sv
verif/content_scan_tb.sv

//--- Makefile
# Verilator build and run of the content scanner testbench

SIM := obj_dir/content_scan_sim

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f content_scan.f \
		--top-module content_scan_tb -o content_scan_sim
	out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

lint:
	verilator --lint-only --timing -Wall -f content_scan.f --top-module content_scan_tb

clean:
	rm -rf obj_dir

//--- verif/content_scan_tb.sv
`timescale 1ns/10ps
`include "scan_macros.svh"

module content_scan_tb;

   import scan_pkg::*;

   // Expected packet result and counter values after that packet
   typedef struct packed {
      scan_result_t res;
      count_t       finger_cnt;
      count_t       root_cnt;
   } expect_t;

   logic                      clk;
   logic                      rst_n;
   logic                      pkt_start;
   pkt_ctl_t                  pkt_ctl;
   char_beat_t                beat;
   logic                      cfg_we;
   logic [`SCAN_STREAM_W-1:0] cfg_stream;
   cat_mask_t                 cfg_enable;
   logic                      result_vld;
   scan_result_t              result;
   count_t                    finger_count;
   count_t                    root_count;

   // Model of the saved automaton state and enables per stream
   finger_state_t model_finger [`SCAN_NUM_STREAMS];
   root_state_t   model_root [`SCAN_NUM_STREAMS];
   cat_mask_t     model_enable [`SCAN_NUM_STREAMS];
   count_t        model_finger_cnt;
   count_t        model_root_cnt;

   expect_t exp_q [$];
   int      checked;
   integer  seed;

   content_scan_top u_dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .pkt_start    (pkt_start),
      .pkt_ctl      (pkt_ctl),
      .beat         (beat),
      .cfg_we       (cfg_we),
      .cfg_stream   (cfg_stream),
      .cfg_enable   (cfg_enable),
      .result_vld   (result_vld),
      .result       (result),
      .finger_count (finger_count),
      .root_count   (root_count)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #5 clk = ~clk;
      end
   end

   task automatic fail_now(input string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic check_result(input scan_result_t got, input scan_result_t want);
      if (got !== want)
      begin
         fail_now($sformatf("error at %0t: stream %0d fired %b, expected stream %0d fired %b",
            $time, got.stream_id, got.fired, want.stream_id, want.fired));
      end
   endtask

   task automatic check_count(input count_t got, input count_t want, input string name);
      if (got !== want)
      begin
         fail_now($sformatf("error at %0t: %s is %0d, expected %0d",
            $time, name, got, want));
      end
   endtask

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // One character through the "finger" automaton
   function automatic finger_state_t finger_step(input finger_state_t s, input logic [7:0] c,
                                                output logic hit);
      string         word;
      logic [7:0]    want;
      finger_state_t n;
      word = "finger";
      want = word[s];
      hit  = 1'b0;
      if (c == want)
      begin
         // Last letter completes the word and the run starts over
         if (s == 3'd5)
         begin
            hit = 1'b1;
            n   = '0;
         end
         else
         begin
            n = s + 3'd1;
         end
      end
      else if (c == "f")
      begin
         n = 3'd1;
      end
      else
      begin
         n = '0;
      end
      return n;
   endfunction

   // One character through the line-start "root" automaton
   function automatic root_state_t root_step(input root_state_t s, input logic [7:0] c,
                                            output logic hit);
      string       word;
      logic [7:0]  want;
      root_state_t n;
      word = "root";
      want = word[s.progress[1:0]];
      hit  = 1'b0;
      if (c == 8'h0a)
      begin
         n.line_start = 1'b1;
         n.progress   = 3'd0;
      end
      else
      begin
         n.line_start = 1'b0;
         n.progress   = ROOT_NO_RUN;
         // Progress 0 only exists at a line start or on a fresh stream
         if (s.progress <= 3'd3 && c == want)
         begin
            if (s.progress == 3'd3)
            begin
               hit = 1'b1;
            end
            else
            begin
               n.progress = s.progress + 3'd1;
            end
         end
      end
      return n;
   endfunction

   // Expected result of a whole packet, updates the model
   function automatic scan_result_t expected_result(input logic [`SCAN_STREAM_W-1:0] sid,
                                                   input logic new_stream, input string text);
      finger_state_t fs;
      root_state_t   rs;
      logic          f_hit;
      logic          r_hit;
      logic          hit;
      scan_result_t  res;
      fs    = new_stream ? finger_state_t'('0) : model_finger[sid];
      rs    = new_stream ? root_state_t'('0) : model_root[sid];
      f_hit = 1'b0;
      r_hit = 1'b0;
      for (int i = 0; i < text.len(); i++)
      begin
         fs    = finger_step(fs, text[i], hit);
         f_hit = f_hit | hit;
         rs    = root_step(rs, text[i], hit);
         r_hit = r_hit | hit;
      end
      // Disabled category keeps its older saved state and its count
      if (model_enable[sid][CAT_FINGER])
      begin
         model_finger[sid] = fs;
         model_finger_cnt  = model_finger_cnt + count_t'(f_hit);
      end
      if (model_enable[sid][CAT_ROOT])
      begin
         model_root[sid] = rs;
         model_root_cnt  = model_root_cnt + count_t'(r_hit);
      end
      res.stream_id         = sid;
      res.fired[CAT_FINGER] = model_enable[sid][CAT_FINGER] & f_hit;
      res.fired[CAT_ROOT]   = model_enable[sid][CAT_ROOT] & r_hit;
      return res;
   endfunction

   // Random text from single letters and pieces of both words
   function automatic string random_text();
      string text;
      string alpha;
      string chunks [7];
      int    items;
      text   = "";
      alpha  = "fingerotx\n ";
      chunks = '{"finger", "fin", "ger", "\nroot", "root", "ro", "ot"};
      items  = 1 + rand_below(6);
      for (int i = 0; i < items; i++)
      begin
         if (rand_below(8) < 5)
         begin
            text = $sformatf("%s%c", text, alpha[rand_below(alpha.len())]);
         end
         else
         begin
            text = {text, chunks[rand_below(7)]};
         end
      end
      return text;
   endfunction

   task automatic configure(input logic [`SCAN_STREAM_W-1:0] sid, input cat_mask_t en);
      @(posedge clk);
      cfg_we     <= 1'b1;
      cfg_stream <= sid;
      cfg_enable <= en;
      @(posedge clk);
      cfg_we <= 1'b0;
      model_enable[sid] = en;
   endtask

   // Waits until every pushed result has been compared
   task automatic wait_results();
      int cycles;
      cycles = 0;
      while (exp_q.size() != 0)
      begin
         @(posedge clk);
         cycles++;
         if (cycles > 20)
         begin
            fail_now("Timed out waiting for result_vld");
         end
      end
   endtask

   task automatic send_packet(input logic [`SCAN_STREAM_W-1:0] sid, input logic new_stream,
                              input string text, input logic gaps);
      expect_t want;
      @(posedge clk);
      pkt_start          <= 1'b1;
      pkt_ctl.stream_id  <= sid;
      pkt_ctl.new_stream <= new_stream;
      @(posedge clk);
      pkt_start <= 1'b0;
      for (int i = 0; i < text.len(); i++)
      begin
         if (gaps)
         begin
            repeat (rand_below(3))
            begin
               beat.vld <= 1'b0;
               beat.eop <= 1'b0;
               @(posedge clk);
            end
         end
         beat.char <= text[i];
         beat.vld  <= 1'b1;
         beat.eop  <= (i == text.len() - 1);
         @(posedge clk);
      end
      beat <= '0;
      want.res        = expected_result(sid, new_stream, text);
      want.finger_cnt = model_finger_cnt;
      want.root_cnt   = model_root_cnt;
      exp_q.push_back(want);
      wait_results();
   endtask

   // Compare at the falling edge where DUT outputs are settled
   initial
   begin : compare_results
      expect_t want;
      forever
      begin
         @(negedge clk);
         if (result_vld === 1'b1)
         begin
            if (exp_q.size() == 0)
            begin
               fail_now("A result came out with no packet outstanding");
            end
            else
            begin
               want = exp_q.pop_front();
               check_result(result, want.res);
               check_count(finger_count, want.finger_cnt, "finger_count");
               check_count(root_count, want.root_cnt, "root_count");
               checked++;
            end
         end
      end
   end

   initial
   begin
      logic [`SCAN_STREAM_W-1:0] sid;
      rst_n            = 1'b0;
      pkt_start        = 1'b0;
      pkt_ctl          = '0;
      beat             = '0;
      cfg_we           = 1'b0;
      cfg_stream       = '0;
      cfg_enable       = '0;
      seed             = 13904;
      checked          = 0;
      model_finger_cnt = '0;
      model_root_cnt   = '0;
      foreach (model_enable[i])
      begin
         model_enable[i] = '0;
         model_finger[i] = '0;
         model_root[i]   = '0;
      end
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);

      // Whole word in one packet, then a packet without it
      configure(6'd10, 2'b11);
      send_packet(6'd10, 1'b1, "get finger now", 1'b0);
      send_packet(6'd10, 1'b0, "nothing here", 1'b0);

      // Word split over two packets, with and without new_stream
      configure(6'd11, 2'b11);
      send_packet(6'd11, 1'b1, "xxfin", 1'b0);
      send_packet(6'd11, 1'b0, "gerxx", 1'b1);
      send_packet(6'd11, 1'b0, "a fin", 1'b0);
      send_packet(6'd11, 1'b1, "ger", 1'b0);

      // Root at stream start, after newlines, and mid line
      configure(6'd12, 2'b11);
      configure(6'd13, 2'b11);
      send_packet(6'd12, 1'b1, "root", 1'b0);
      send_packet(6'd12, 1'b0, "abc\nroot", 1'b0);
      send_packet(6'd13, 1'b1, "xroot", 1'b0);
      send_packet(6'd13, 1'b0, "ab\n", 1'b0);
      send_packet(6'd13, 1'b0, "root", 1'b1);

      // Finger off for one packet, then resumes from "fin"
      configure(6'd14, 2'b11);
      send_packet(6'd14, 1'b1, "xfin", 1'b0);
      configure(6'd14, 2'b10);
      send_packet(6'd14, 1'b0, "ger", 1'b0);
      configure(6'd14, 2'b11);
      send_packet(6'd14, 1'b0, "ger", 1'b0);

      // Random traffic, every stream opened once with both enabled
      for (int s = 0; s < 8; s++)
      begin
         configure(6'(s), 2'b11);
         send_packet(6'(s), 1'b1, random_text(), 1'b1);
      end
      for (int n = 0; n < 150; n++)
      begin
         sid = 6'(rand_below(8));
         if (rand_below(6) == 0)
         begin
            configure(sid, cat_mask_t'(rand_below(4)));
         end
         send_packet(sid, rand_below(10) == 0, random_text(), 1'b1);
      end

      wait_results();
      if (exp_q.size() != 0 || checked == 0)
      begin
         fail_now("Run ended without every packet result checked");
      end
      else
      begin
         $display("Regression passed");
         $finish;
      end
   end

endmodule

//--- verif/content_scan_sva.sv
`timescale 1ns/10ps

module content_scan_sva (
   input logic             clk,
   input logic             rst_n,
   input logic             load_state,
   input logic             finalize,
   input logic             state_in_vld,
   input logic             fired_vld,
   input scan_pkg::count_t count
);

   // Restored state reaches the matcher one cycle after the load
   a_load_restore: assert property (@(posedge clk) disable iff (!rst_n)
      load_state |=> state_in_vld)
      else $error("state_in_vld did not follow load_state");

   // Result of the unit one cycle after finalize
   a_finalize_result: assert property (@(posedge clk) disable iff (!rst_n)
      finalize |=> fired_vld)
      else $error("fired_vld did not follow finalize");

   // Fired-packet counter only moves up
   a_count_up: assert property (@(posedge clk) disable iff (!rst_n)
      count >= $past(count))
      else $error("fired-packet counter decreased");

endmodule

bind stream_ctx_unit content_scan_sva u_sva (
   .clk          (clk),
   .rst_n        (rst_n),
   .load_state   (load_state),
   .finalize     (finalize),
   .state_in_vld (state_in_vld),
   .fired_vld    (fired_vld),
   .count        (count)
);

//--- design/content_scan_top.sv
`timescale 1ns/10ps
`include "scan_macros.svh"

module content_scan_top (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      pkt_start,
   input  scan_pkg::pkt_ctl_t        pkt_ctl,
   input  scan_pkg::char_beat_t      beat,
   input  logic                      cfg_we,
   input  logic [`SCAN_STREAM_W-1:0] cfg_stream,
   input  scan_pkg::cat_mask_t       cfg_enable,
   output logic                      result_vld,
   output scan_pkg::scan_result_t    result,
   output scan_pkg::count_t          finger_count,
   output scan_pkg::count_t          root_count
);

   import scan_pkg::*;

   // Dispatcher outputs
   logic       load_state;
   logic       finalize;
   pkt_ctl_t   cur_ctl;
   cat_mask_t  enable;
   char_beat_t beat_q;

   // Finger category path
   finger_state_t finger_state_in;
   finger_state_t finger_state_out;
   logic          finger_state_in_vld;
   logic          finger_accept;

   // Root category path
   root_state_t root_state_in;
   root_state_t root_state_out;
   logic        root_state_in_vld;
   logic        root_accept;

   // Per-category results
   cat_mask_t fired;
   cat_mask_t fired_vld;

   stream_dispatch u_dispatch (
      .clk        (clk),
      .rst_n      (rst_n),
      .pkt_start  (pkt_start),
      .pkt_ctl    (pkt_ctl),
      .beat       (beat),
      .cfg_we     (cfg_we),
      .cfg_stream (cfg_stream),
      .cfg_enable (cfg_enable),
      .load_state (load_state),
      .finalize   (finalize),
      .cur_ctl    (cur_ctl),
      .enable     (enable),
      .beat_q     (beat_q)
   );

   stream_ctx_unit #(
      .state_t (finger_state_t)
   ) u_ctx_finger (
      .clk          (clk),
      .rst_n        (rst_n),
      .load_state   (load_state),
      .finalize     (finalize),
      .new_stream   (cur_ctl.new_stream),
      .enable       (enable[CAT_FINGER]),
      .stream_id    (cur_ctl.stream_id),
      .state_out    (finger_state_out),
      .accept       (finger_accept),
      .state_in     (finger_state_in),
      .state_in_vld (finger_state_in_vld),
      .fired        (fired[CAT_FINGER]),
      .fired_vld    (fired_vld[CAT_FINGER]),
      .count        (finger_count)
   );

   finger_matcher u_finger (
      .clk          (clk),
      .rst_n        (rst_n),
      .beat         (beat_q),
      .state_in     (finger_state_in),
      .state_in_vld (finger_state_in_vld),
      .state_out    (finger_state_out),
      .accept       (finger_accept)
   );

   stream_ctx_unit #(
      .state_t (root_state_t)
   ) u_ctx_root (
      .clk          (clk),
      .rst_n        (rst_n),
      .load_state   (load_state),
      .finalize     (finalize),
      .new_stream   (cur_ctl.new_stream),
      .enable       (enable[CAT_ROOT]),
      .stream_id    (cur_ctl.stream_id),
      .state_out    (root_state_out),
      .accept       (root_accept),
      .state_in     (root_state_in),
      .state_in_vld (root_state_in_vld),
      .fired        (fired[CAT_ROOT]),
      .fired_vld    (fired_vld[CAT_ROOT]),
      .count        (root_count)
   );

   root_matcher u_root (
      .clk          (clk),
      .rst_n        (rst_n),
      .beat         (beat_q),
      .state_in     (root_state_in),
      .state_in_vld (root_state_in_vld),
      .state_out    (root_state_out),
      .accept       (root_accept)
   );

   // Both units finalize on the same cycle
   assign result_vld = &fired_vld;

   // Stream id is held until the next pkt_start
   // which comes after the result
   assign result.stream_id = cur_ctl.stream_id;
   assign result.fired     = fired;

endmodule

//--- matchers/root_matcher.sv
`timescale 1ns/10ps

module root_matcher (
   input  logic                  clk,
   input  logic                  rst_n,
   input  scan_pkg::char_beat_t  beat,
   input  scan_pkg::root_state_t state_in,
   input  logic                  state_in_vld,
   output scan_pkg::root_state_t state_out,
   output logic                  accept
);

   import scan_pkg::*;

   localparam logic [7:0] NEWLINE = 8'h0a;

   root_state_t base;
   root_state_t next;
   logic        at_start;
   logic        hit;

   always_comb
   begin
      base = state_in_vld ? state_in : state_out;
      // All-zero state is a fresh stream and counts as a line start
      at_start = base.line_start | (base == '0);
      next     = base;
      hit      = 1'b0;
      if (beat.vld)
      begin
         if (beat.char == NEWLINE)
         begin
            next.line_start = 1'b1;
            next.progress   = 3'd0;
         end
         else
         begin
            next.line_start = 1'b0;
            next.progress   = ROOT_NO_RUN;
            case (base.progress)
               3'd0:
               begin
                  // A run may only open at a line start
                  if (at_start && beat.char == "r")
                  begin
                     next.progress = 3'd1;
                  end
               end
               3'd1:
               begin
                  if (beat.char == "o")
                  begin
                     next.progress = 3'd2;
                  end
               end
               3'd2:
               begin
                  if (beat.char == "o")
                  begin
                     next.progress = 3'd3;
                  end
               end
               3'd3:
               begin
                  // Word complete, rest of the line cannot match
                  hit = (beat.char == "t");
               end
               default:
               begin
                  next.progress = ROOT_NO_RUN;
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_out <= '0;
         accept    <= 1'b0;
      end
      else
      begin
         state_out <= next;
         accept    <= hit;
      end
   end

endmodule

//--- matchers/finger_matcher.sv
`timescale 1ns/10ps

module finger_matcher (
   input  logic                    clk,
   input  logic                    rst_n,
   input  scan_pkg::char_beat_t    beat,
   input  scan_pkg::finger_state_t state_in,
   input  logic                    state_in_vld,
   output scan_pkg::finger_state_t state_out,
   output logic                    accept
);

   import scan_pkg::*;

   finger_state_t base;
   finger_state_t next;
   logic          hit;
   logic [7:0]    want;

   // Next letter of "finger" for the current progress
   always_comb
   begin
      case (base)
         3'd0:    want = "f";
         3'd1:    want = "i";
         3'd2:    want = "n";
         3'd3:    want = "g";
         3'd4:    want = "e";
         3'd5:    want = "r";
         default: want = 8'h00;
      endcase
   end

   always_comb
   begin
      // Restored state overrides the running one
      base = state_in_vld ? state_in : state_out;
      next = base;
      hit  = 1'b0;
      if (beat.vld)
      begin
         if (beat.char == want)
         begin
            if (base == 3'd5)
            begin
               // Full word seen, start over
               hit  = 1'b1;
               next = 3'd0;
            end
            else
            begin
               next = base + 3'd1;
            end
         end
         else if (beat.char == "f")
         begin
            next = 3'd1;   // mismatch on an f opens a new run
         end
         else
         begin
            next = 3'd0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_out <= '0;
         accept    <= 1'b0;
      end
      else
      begin
         state_out <= next;
         accept    <= hit;
      end
   end

endmodule

//--- stream_ctx/stream_ctx_unit.sv
`timescale 1ns/10ps
`include "scan_macros.svh"

module stream_ctx_unit #(
   parameter type state_t = logic [2:0]
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      load_state,
   input  logic                      finalize,
   input  logic                      new_stream,
   input  logic                      enable,
   input  logic [`SCAN_STREAM_W-1:0] stream_id,
   input  state_t                    state_out,
   input  logic                      accept,
   output state_t                    state_in,
   output logic                      state_in_vld,
   output logic                      fired,
   output logic                      fired_vld,
   output scan_pkg::count_t          count
);

   import scan_pkg::*;

   // Saved matcher state per stream
   // First use of a stream always comes with new_stream
   state_t state_mem [`SCAN_NUM_STREAMS];

   // Set by any accept inside the current packet
   logic spec_match;

   // Packet hit including an accept on the last character
   logic pkt_hit;

   assign pkt_hit = spec_match | accept;

   // Restore path
   // New stream starts the matcher from its reset state
   always_ff @(posedge clk)
   begin
      if (load_state)
      begin
         if (new_stream)
         begin
            state_in <= state_t'('0);
         end
         else
         begin
            state_in <= state_mem[stream_id];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_in_vld <= 1'b0;
      end
      else
      begin
         state_in_vld <= load_state;
      end
   end

   // Save path
   // A disabled category keeps the state from before it was disabled
   always_ff @(posedge clk)
   begin
      if (finalize && enable)
      begin
         state_mem[stream_id] <= state_out;
      end
   end

   // Speculative flag, result and counter
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         spec_match <= 1'b0;
         fired      <= 1'b0;
         fired_vld  <= 1'b0;
         count      <= '0;
      end
      else
      begin
         // Clear at packet start, set on every accept
         if (load_state)
         begin
            spec_match <= 1'b0;
         end
         else if (accept)
         begin
            spec_match <= 1'b1;
         end

         fired_vld <= finalize;
         if (finalize)
         begin
            fired <= enable & pkt_hit;
            if (enable)
            begin
               count <= count + count_t'(pkt_hit);
            end
         end
      end
   end

endmodule

//--- design/stream_dispatch.sv
`timescale 1ns/10ps
`include "scan_macros.svh"

module stream_dispatch (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      pkt_start,
   input  scan_pkg::pkt_ctl_t        pkt_ctl,
   input  scan_pkg::char_beat_t      beat,
   input  logic                      cfg_we,
   input  logic [`SCAN_STREAM_W-1:0] cfg_stream,
   input  scan_pkg::cat_mask_t       cfg_enable,
   output logic                      load_state,
   output logic                      finalize,
   output scan_pkg::pkt_ctl_t        cur_ctl,
   output scan_pkg::cat_mask_t       enable,
   output scan_pkg::char_beat_t      beat_q
);

   import scan_pkg::*;

   // Per-stream category enables
   cat_mask_t enable_tbl [`SCAN_NUM_STREAMS];

   // Enable table writes
   // Only applied between packets so no bypass to the read below
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < `SCAN_NUM_STREAMS; i++)
         begin
            enable_tbl[i] <= '0;
         end
      end
      else if (cfg_we)
      begin
         enable_tbl[cfg_stream] <= cfg_enable;
      end
   end

   // Packet control held for the whole packet
   always_ff @(posedge clk)
   begin
      if (pkt_start)
      begin
         cur_ctl <= pkt_ctl;
      end
   end

   // Load pulse and enable lookup one cycle after pkt_start
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         load_state <= 1'b0;
         enable     <= '0;
      end
      else
      begin
         load_state <= pkt_start;
         if (pkt_start)
         begin
            enable <= enable_tbl[pkt_ctl.stream_id];
         end
      end
   end

   // Beat delay stage
   // Finalize trails the registered eop beat by one cycle
   // so that the matcher's accept for the last character is out
   always_ff @(posedge clk)
   begin
      beat_q.char <= beat.char;
      if (!rst_n)
      begin
         beat_q.vld <= 1'b0;
         beat_q.eop <= 1'b0;
         finalize   <= 1'b0;
      end
      else
      begin
         beat_q.vld <= beat.vld;
         beat_q.eop <= beat.eop;
         finalize   <= beat_q.vld & beat_q.eop;
      end
   end

endmodule

//--- common/scan_pkg.sv
`include "scan_macros.svh"

package scan_pkg;

   // One input character per cycle
   typedef struct packed {
      logic [7:0] char;
      logic       vld;
      logic       eop;   // Set with the last character of a packet
   } char_beat_t;

   // Packet start command
   typedef struct packed {
      logic [`SCAN_STREAM_W-1:0] stream_id;
      logic                      new_stream;
   } pkt_ctl_t;

   // Letters of "finger" matched so far
   typedef logic [2:0] finger_state_t;

   // Line-start tracking plus letters of "root" matched so far
   typedef struct packed {
      logic       line_start;
      logic [2:0] progress;
   } root_state_t;

   // Progress code for a line already under way with no run open
   localparam logic [2:0] ROOT_NO_RUN = 3'd7;

   // Category index into the masks
   typedef enum logic {
      CAT_FINGER = 1'b0,
      CAT_ROOT   = 1'b1
   } cat_idx_e;

   localparam int NUM_CATS = 2;

   // One bit per category
   typedef logic [NUM_CATS-1:0] cat_mask_t;

   typedef logic [`SCAN_COUNT_W-1:0] count_t;

   // End of packet report
   typedef struct packed {
      logic [`SCAN_STREAM_W-1:0] stream_id;
      cat_mask_t                 fired;
   } scan_result_t;

endpackage

//--- common/scan_macros.svh
`ifndef SCAN_MACROS_SVH
`define SCAN_MACROS_SVH

// Number of stream contexts kept by each category
`define SCAN_NUM_STREAMS 64

// Stream id width
// Must cover SCAN_NUM_STREAMS
`define SCAN_STREAM_W 6

// Width of the fired-packet counters
`define SCAN_COUNT_W 16

`endif
